// File: Bender.yml
package:
  name: ipod_player

sources:
  - files:
      - design/ipod_pkg.sv
      - design/player_regs.sv
      - design/speed_ctrl.sv
      - design/sample_tick_gen.sv
      - design/flash_sample_fetch.sv
      - design/hex_display.sv
      - design/ipod_top.sv
  - target: test
    files:
      - test/ipod_assertions.sv
      - test/tb_ipod_top.sv

// File: design/flash_sample_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module flash_sample_fetch
  import ipod_pkg::*;
(
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire                   play_en,
  input  wire flash_addr_t      start_addr,
  input  wire flash_addr_t      end_addr,
  input  wire                   sample_tick,
  output logic                  flash_read,
  output flash_addr_t           flash_address,
  input  wire                   flash_waitrequest,
  input  wire flash_word_t      flash_readdata,
  input  wire                   flash_readdatavalid,
  output sample_t               sample,
  output logic                  sample_valid,
  output logic [UNDERRUN_W-1:0] underrun_count
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} rd_state_t;

  rd_state_t   state;
  flash_addr_t addr_q;
  flash_word_t word_buf;
  logic        buf_full;
  logic        half_hi;
  logic        play_q;
  logic        stale;
  logic        play_rise;
  logic        running;
  logic        data_in;
  logic        take_word;
  logic        consume;

  assign play_rise = play_en & ~play_q;
  // Wait one cycle after a start so the loop address is loaded
  assign running   = play_en & play_q;
  assign data_in   = (state == ST_WAIT) && flash_readdatavalid;
  // Data of a read issued before a restart is thrown away
  assign take_word = data_in && !stale && !play_rise;
  assign consume   = running && sample_tick && buf_full;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      play_q <= 1'b0;
    else
      play_q <= play_en;
  end

  //====================================================================
  // Read FSM, one read in flight at most
  //====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE: if (running && !buf_full) state <= ST_REQ;
        ST_REQ:  if (!flash_waitrequest) state <= ST_WAIT;
        ST_WAIT: if (flash_readdatavalid) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign flash_read = (state == ST_REQ);

  // Held while the request waits
  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_IDLE)
      flash_address <= addr_q;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      stale <= 1'b0;
    else if (play_rise)
      stale <= (state == ST_REQ) || ((state == ST_WAIT) && !flash_readdatavalid);
    else if (data_in)
      stale <= 1'b0;
  end

  // Loop address, wraps after end_addr
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      addr_q <= '0;
    else if (play_rise)
      addr_q <= start_addr;
    else if (take_word)
      addr_q <= (addr_q == end_addr) ? start_addr : addr_q + 1'b1;
  end

  //====================================================================
  // Word buffer and sample output
  //====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (take_word)
      word_buf <= flash_readdata;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      buf_full <= 1'b0;
      half_hi  <= 1'b0;
    end
    else if (play_rise)
    begin
      buf_full <= 1'b0;
      half_hi  <= 1'b0;
    end
    else if (take_word)
      buf_full <= 1'b1;
    else if (consume)
    begin
      half_hi <= ~half_hi;
      // High half gone, so the word is free for the next read
      if (half_hi)
        buf_full <= 1'b0;
    end
  end

  // Low half first
  always_ff @(posedge CLK_50M)
  begin
    if (consume)
      sample <= half_hi ? sample_t'(word_buf[31:16]) : sample_t'(word_buf[15:0]);
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_valid <= 1'b0;
    else
      sample_valid <= consume;
  end

  // Ticks that find no data, saturating
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      underrun_count <= '0;
    else if (running && sample_tick && !buf_full && (underrun_count != '1))
      underrun_count <= underrun_count + 1'b1;
  end

endmodule

`default_nettype wire

// File: design/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display
  import ipod_pkg::*;
(
  input  wire           CLK_50M,
  input  wire           rst_n,
  input  wire divider_t divider,
  output seg7_t         hex [HEX_DIGITS]
);

  localparam int VALUE_W = 4 * HEX_DIGITS;

  logic [VALUE_W-1:0] value;

  // Upper digits show zero
  assign value = VALUE_W'(divider);

  // Standard hex glyphs, active low
  function automatic seg7_t glyph(input logic [3:0] nib);
    seg7_t seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // Digit 0 is the least significant nibble
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < HEX_DIGITS; i++)
        hex[i] <= '1;
    end
    else
    begin
      for (int i = 0; i < HEX_DIGITS; i++)
        hex[i] <= glyph(value[4*i +: 4]);
    end
  end

endmodule

`default_nettype wire

// File: design/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  //====================================================================
  // Widths and shared types
  //====================================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int UNDERRUN_W   = 16;
  localparam int HEX_DIGITS   = 6;

  // Flash word address, one 32-bit word per address
  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [31:0]             flash_word_t;

  // Two of these are packed in each flash word
  typedef logic signed [15:0] sample_t;

  // Sample period in clock cycles, minus one
  typedef logic [15:0] divider_t;

  // Active low, segment a on bit 0 up to g on bit 6
  typedef logic [6:0] seg7_t;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  //====================================================================
  // Register map (byte offsets)
  //====================================================================
  localparam apb_addr_t REG_CTRL     = 8'h00;
  localparam apb_addr_t REG_START    = 8'h04;
  localparam apb_addr_t REG_END      = 8'h08;
  localparam apb_addr_t REG_DIVIDER  = 8'h0C;
  localparam apb_addr_t REG_UNDERRUN = 8'h10;

endpackage

`default_nettype wire

// File: design/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top
  import ipod_pkg::*;
#(
  parameter divider_t DEFAULT_DIVIDER = 16'd12499,
  parameter divider_t SPEED_STEP      = 16'd100,
  parameter divider_t MIN_DIVIDER     = 16'd1000,
  parameter divider_t MAX_DIVIDER     = 16'd50000,
  parameter int       REPEAT_CYCLES   = 5000000
)
(
  input  wire              CLK_50M,
  input  wire              rst_n,
  // APB slave
  input  wire apb_addr_t   paddr,
  input  wire              psel,
  input  wire              penable,
  input  wire              pwrite,
  input  wire apb_data_t   pwdata,
  output apb_data_t        prdata,
  output logic             pready,
  output logic             pslverr,
  // Speed keys, already synchronized
  input  wire              speed_up,
  input  wire              speed_down,
  input  wire              speed_reset,
  // Flash read port
  output logic             flash_read,
  output flash_addr_t      flash_address,
  input  wire              flash_waitrequest,
  input  wire flash_word_t flash_readdata,
  input  wire              flash_readdatavalid,
  // Audio out and display
  output sample_t          sample,
  output logic             sample_valid,
  output seg7_t            hex [HEX_DIGITS]
);

  logic                  play_en;
  flash_addr_t           start_addr;
  flash_addr_t           end_addr;
  logic [UNDERRUN_W-1:0] underrun_count;
  divider_t              divider;
  logic                  sample_tick;

  //====================================================================
  // Control path
  //====================================================================
  player_regs player_regs_inst (
    .CLK_50M        (CLK_50M),
    .rst_n          (rst_n),
    .paddr          (paddr),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .divider        (divider),
    .underrun_count (underrun_count),
    .play_en        (play_en),
    .start_addr     (start_addr),
    .end_addr       (end_addr)
  );

  speed_ctrl #(
    .DEFAULT_DIVIDER (DEFAULT_DIVIDER),
    .SPEED_STEP      (SPEED_STEP),
    .MIN_DIVIDER     (MIN_DIVIDER),
    .MAX_DIVIDER     (MAX_DIVIDER),
    .REPEAT_CYCLES   (REPEAT_CYCLES)
  ) speed_ctrl_inst (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divider     (divider)
  );

  //====================================================================
  // Sample path
  //====================================================================
  sample_tick_gen sample_tick_gen_inst (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .divider     (divider),
    .sample_tick (sample_tick)
  );

  flash_sample_fetch flash_sample_fetch_inst (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .play_en             (play_en),
    .start_addr          (start_addr),
    .end_addr            (end_addr),
    .sample_tick         (sample_tick),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .underrun_count      (underrun_count)
  );

  hex_display hex_display_inst (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .divider (divider),
    .hex     (hex)
  );

endmodule

`default_nettype wire

// File: design/player_regs.sv
`timescale 1ns/1ps
`default_nettype none

module player_regs
  import ipod_pkg::*;
(
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire apb_addr_t        paddr,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire apb_data_t        pwdata,
  output apb_data_t             prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  wire divider_t         divider,
  input  wire [UNDERRUN_W-1:0]  underrun_count,
  output logic                  play_en,
  output flash_addr_t           start_addr,
  output flash_addr_t           end_addr
);

  logic access;
  logic mapped;
  logic read_only;
  logic wr_en;

  // Access phase of a transfer, no wait states
  assign access = psel & penable;
  assign pready = 1'b1;

  //====================================================================
  // Offset decode
  //====================================================================
  always_comb
  begin
    mapped    = 1'b1;
    read_only = 1'b0;
    case (paddr)
      REG_CTRL, REG_START, REG_END: read_only = 1'b0;
      REG_DIVIDER, REG_UNDERRUN:    read_only = 1'b1;
      default:                      mapped = 1'b0;
    endcase
  end

  // Bad offsets and writes to status registers are refused
  assign pslverr = access & (~mapped | (pwrite & read_only));
  assign wr_en   = access & pwrite & mapped & ~read_only;

  //====================================================================
  // Writable registers
  //====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      play_en    <= 1'b0;
      start_addr <= '0;
      end_addr   <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        REG_CTRL:  play_en <= pwdata[0];
        REG_START: start_addr <= pwdata[FLASH_ADDR_W-1:0];
        REG_END:   end_addr <= pwdata[FLASH_ADDR_W-1:0];
        default:   play_en <= play_en;
      endcase
    end
  end

  // Read data mux
  always_comb
  begin
    prdata = '0;
    case (paddr)
      REG_CTRL:     prdata = {31'd0, play_en};
      REG_START:    prdata = apb_data_t'(start_addr);
      REG_END:      prdata = apb_data_t'(end_addr);
      REG_DIVIDER:  prdata = apb_data_t'(divider);
      REG_UNDERRUN: prdata = apb_data_t'(underrun_count);
      default:      prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/sample_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sample_tick_gen
  import ipod_pkg::*;
(
  input  wire           CLK_50M,
  input  wire           rst_n,
  input  wire divider_t divider,
  output logic          sample_tick
);

  divider_t period_cnt;
  divider_t period_q;

  // Period is taken from the divider at each wrap
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      period_cnt  <= '0;
      period_q    <= divider;
      sample_tick <= 1'b0;
    end
    else if (period_cnt == period_q)
    begin
      period_cnt  <= '0;
      period_q    <= divider;
      sample_tick <= 1'b1;
    end
    else
    begin
      period_cnt  <= period_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/speed_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module speed_ctrl
  import ipod_pkg::*;
#(
  parameter divider_t DEFAULT_DIVIDER = 16'd12499,
  parameter divider_t SPEED_STEP      = 16'd100,
  parameter divider_t MIN_DIVIDER     = 16'd1000,
  parameter divider_t MAX_DIVIDER     = 16'd50000,
  parameter int       REPEAT_CYCLES   = 5000000
)
(
  input  wire      CLK_50M,
  input  wire      rst_n,
  input  wire      speed_up,
  input  wire      speed_down,
  input  wire      speed_reset,
  output divider_t divider
);

  localparam int CNT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;

  logic [CNT_W-1:0] rep_cnt;
  logic             key_held;
  logic             step_now;
  logic [16:0]      up_limit;
  logic [16:0]      down_sum;
  divider_t         next_up;
  divider_t         next_down;

  assign key_held = speed_up | speed_down;

  // Step on the first held cycle, then once per repeat interval
  assign step_now = key_held && (rep_cnt == '0);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      rep_cnt <= '0;
    else if (!key_held)
      rep_cnt <= '0;
    else if (rep_cnt == CNT_W'(REPEAT_CYCLES - 1))
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  //====================================================================
  // Clamped next values, one extra bit so nothing wraps
  //====================================================================
  assign up_limit = {1'b0, MIN_DIVIDER} + {1'b0, SPEED_STEP};
  assign down_sum = {1'b0, divider} + {1'b0, SPEED_STEP};

  // Faster playback means a shorter period
  assign next_up   = ({1'b0, divider} < up_limit) ? MIN_DIVIDER : divider - SPEED_STEP;
  assign next_down = (down_sum > {1'b0, MAX_DIVIDER}) ? MAX_DIVIDER : down_sum[15:0];

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      divider <= DEFAULT_DIVIDER;
    else if (speed_reset)
      divider <= DEFAULT_DIVIDER;   // wins over up and down
    else if (step_now)
      divider <= speed_up ? next_up : next_down;
  end

endmodule

`default_nettype wire

// File: project.f
design/ipod_pkg.sv
design/player_regs.sv
design/speed_ctrl.sv
design/sample_tick_gen.sv
design/flash_sample_fetch.sv
design/hex_display.sv
design/ipod_top.sv
test/ipod_assertions.sv
test/tb_ipod_top.sv

// File: test/ipod_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_assertions
  import ipod_pkg::*;
(
  input wire              CLK_50M,
  input wire              rst_n,
  input wire              play_en,
  input wire              flash_read,
  input wire flash_addr_t flash_address,
  input wire              flash_waitrequest,
  input wire              flash_readdatavalid,
  input wire              sample_valid
);

  logic in_flight;

  // Assertion failures so far
  int   fail_count = 0;

  // One read between acceptance and its data
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      in_flight <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      in_flight <= 1'b1;
    else if (flash_readdatavalid)
      in_flight <= 1'b0;
  end

  request_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else
    begin
      $error("flash request changed while stalled");
      fail_count++;
    end

  no_strobe_when_stopped: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    $rose(sample_valid) |-> $past(play_en))
    else
    begin
      $error("sample strobe while play disabled");
      fail_count++;
    end

  single_read: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && !flash_waitrequest |-> !in_flight || flash_readdatavalid)
    else
    begin
      $error("second flash read while one is outstanding");
      fail_count++;
    end

endmodule

bind flash_sample_fetch ipod_assertions i_assertions (
  .CLK_50M             (CLK_50M),
  .rst_n               (rst_n),
  .play_en             (play_en),
  .flash_read          (flash_read),
  .flash_address       (flash_address),
  .flash_waitrequest   (flash_waitrequest),
  .flash_readdatavalid (flash_readdatavalid),
  .sample_valid        (sample_valid)
);

`default_nettype wire

// File: test/tb_ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod_top
  import ipod_pkg::*;
;

  localparam divider_t DEF_DIV    = 16'd20;
  localparam divider_t STEP       = 16'd4;
  localparam divider_t MIN_DIV    = 16'd8;
  localparam divider_t MAX_DIV    = 16'd60;
  localparam int       REPEAT     = 16;
  localparam int       CYCLE_LIMIT = 20000;
  localparam int       LOOP_START = 'h10;

  logic        CLK_50M;
  logic        rst_n;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     sample;
  logic        sample_valid;
  seg7_t       hex [HEX_DIGITS];

  int          cycle;
  int          errors;
  int          assert_errors;
  int          tests_run;
  int          tests_failed;
  int          flash_reads;
  string       cur_test;
  logic [31:0] lfsr;
  sample_t     got_samples[$];
  int          got_cycles[$];

  // Flash model state
  logic        pending;
  int          lat_cnt;
  flash_addr_t pend_addr;

  ipod_top #(
    .DEFAULT_DIVIDER (DEF_DIV),
    .SPEED_STEP      (STEP),
    .MIN_DIVIDER     (MIN_DIV),
    .MAX_DIVIDER     (MAX_DIV),
    .REPEAT_CYCLES   (REPEAT)
  ) i_dut (.*);

  always #10 CLK_50M = ~CLK_50M;

  //====================================================================
  // Flash model answering three cycles after acceptance
  //====================================================================
  function automatic flash_word_t flash_word(input flash_addr_t a);
    return {a[15:0] ^ 16'h5A5A, a[15:0]};
  endfunction

  always @(posedge CLK_50M)
  begin
    flash_readdatavalid <= 1'b0;
    if (pending)
    begin
      if (lat_cnt == 1)
      begin
        flash_readdatavalid <= 1'b1;
        flash_readdata      <= flash_word(pend_addr);
        pending             <= 1'b0;
      end
      else
        lat_cnt <= lat_cnt - 1;
    end
    if (flash_read && !flash_waitrequest)
    begin
      pending     <= 1'b1;
      lat_cnt     <= 3;
      pend_addr   <= flash_address;
      flash_reads <= flash_reads + 1;
    end
  end

  // Sample capture and run limit
  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
    if (rst_n && sample_valid)
    begin
      got_samples.push_back(sample);
      got_cycles.push_back(cycle);
    end
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles, a test did not finish", cycle);
      $display("Some tests failed");
      $finish;
    end
  end

  //====================================================================
  // Helpers
  //====================================================================
  function automatic logic lfsr_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic int lfsr_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | lfsr_bit();
    return v;
  endfunction

  function automatic seg7_t seg_of(input logic [3:0] n);
    // Active low with segment a on bit 0
    case (n)
      4'h0: return 7'b100_0000;
      4'h1: return 7'b111_1001;
      4'h2: return 7'b010_0100;
      4'h3: return 7'b011_0000;
      4'h4: return 7'b001_1001;
      4'h5: return 7'b001_0010;
      4'h6: return 7'b000_0010;
      4'h7: return 7'b111_1000;
      4'h8: return 7'b000_0000;
      4'h9: return 7'b001_0000;
      4'hA: return 7'b000_1000;
      4'hB: return 7'b000_0011;
      4'hC: return 7'b100_0110;
      4'hD: return 7'b010_0001;
      4'hE: return 7'b000_0110;
      default: return 7'b000_1110;
    endcase
  endfunction

  function automatic sample_t sample_at(input int i);
    flash_addr_t a;
    a = flash_addr_t'(LOOP_START + (i / 2) % 3);
    return (i % 2) ? sample_t'(a[15:0] ^ 16'h5A5A) : sample_t'(a[15:0]);
  endfunction

  function automatic divider_t step_div(input divider_t d, input logic up);
    int nd;
    nd = up ? int'(d) - int'(STEP) : int'(d) + int'(STEP);
    if (nd < MIN_DIV)
      nd = MIN_DIV;
    if (nd > MAX_DIV)
      nd = MAX_DIV;
    return divider_t'(nd);
  endfunction

  task automatic check_data(input string what, input apb_data_t exp, input apb_data_t act);
    if (exp !== act)
    begin
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_sample(input string what, input sample_t exp, input sample_t act);
    if (exp !== act)
    begin
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_divider(input string what, input divider_t exp, input divider_t act);
    if (exp !== act)
    begin
      $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_seg(input string what, input seg7_t exp, input seg7_t act);
    if (exp !== act)
    begin
      $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic apb_xfer(input apb_addr_t a, input logic wr, input apb_data_t d,
                          output apb_data_t rd, output logic err);
    @(posedge CLK_50M);
    paddr   <= a;
    pwrite  <= wr;
    pwdata  <= d;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge CLK_50M);
    penable <= 1'b1;
    @(negedge CLK_50M);
    rd  = prdata;
    err = pslverr;
    check_data("pready in access phase", 32'd1, apb_data_t'(pready));
    @(posedge CLK_50M);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input apb_addr_t a, input apb_data_t d, input logic exp_err);
    apb_data_t rd;
    logic      err;
    apb_xfer(a, 1'b1, d, rd, err);
    check_data($sformatf("pslverr on write %h", a), apb_data_t'(exp_err), apb_data_t'(err));
  endtask

  task automatic reg_check(input apb_addr_t a, input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    apb_xfer(a, 1'b0, '0, rd, err);
    check_data($sformatf("read %h", a), exp, rd);
    check_data($sformatf("pslverr on read %h", a), '0, apb_data_t'(err));
  endtask

  task automatic reg_read(input apb_addr_t a, output apb_data_t rd);
    logic err;
    apb_xfer(a, 1'b0, '0, rd, err);
  endtask

  task automatic hold_key(input int which, input int h);
    @(posedge CLK_50M);
    if (which == 0)
      speed_up <= 1'b1;
    else if (which == 1)
      speed_down <= 1'b1;
    else
      speed_reset <= 1'b1;
    repeat (h) @(posedge CLK_50M);
    speed_up    <= 1'b0;
    speed_down  <= 1'b0;
    speed_reset <= 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int t;
    t = 0;
    while (got_samples.size() < n && t < 2000)
    begin
      @(negedge CLK_50M);
      t++;
    end
    if (got_samples.size() < n)
    begin
      $display("%s: samples stopped arriving, got %0d of %0d", cur_test,
               got_samples.size(), n);
      errors++;
    end
  endtask

  //====================================================================
  // Tests
  //====================================================================
  task automatic test_regs();
    apb_data_t rd;
    logic      err;
    cur_test = "test_regs";
    reg_check(REG_CTRL, '0);
    reg_check(REG_START, '0);
    reg_check(REG_END, '0);
    reg_check(REG_DIVIDER, apb_data_t'(DEF_DIV));
    reg_check(REG_UNDERRUN, '0);
    reg_write(REG_START, 32'hFFFF_FFFF, 1'b0);
    reg_check(REG_START, 32'h007F_FFFF);
    reg_write(REG_END, 32'h0012_3456, 1'b0);
    reg_check(REG_END, 32'h0012_3456);
    reg_write(REG_CTRL, 32'hFFFF_FFFE, 1'b0);
    reg_check(REG_CTRL, '0);
    apb_xfer(8'h14, 1'b0, '0, rd, err);
    check_data("pslverr on unmapped read", 32'd1, apb_data_t'(err));
    reg_write(REG_DIVIDER, 32'h0000_0033, 1'b1);
    reg_check(REG_DIVIDER, apb_data_t'(DEF_DIV));
  endtask

  task automatic test_speed();
    divider_t  exp;
    apb_data_t rd;
    int        h;
    cur_test = "test_speed";
    exp = DEF_DIV;
    hold_key(0, 1);
    exp = step_div(exp, 1'b1);
    reg_read(REG_DIVIDER, rd);
    check_divider("single up", exp, divider_t'(rd));
    hold_key(1, 1);
    exp = step_div(exp, 1'b0);
    reg_read(REG_DIVIDER, rd);
    check_divider("single down", exp, divider_t'(rd));
    for (int k = 0; k < 4; k++)
    begin
      h = 1 + lfsr_bits(6);
      for (int s = 0; s < 1 + (h - 1) / REPEAT; s++)
        exp = step_div(exp, k[0]);
      hold_key(k[0] ? 0 : 1, h);
      reg_read(REG_DIVIDER, rd);
      check_divider($sformatf("hold %0d cycles", h), exp, divider_t'(rd));
    end
    hold_key(2, 1);
    reg_read(REG_DIVIDER, rd);
    check_divider("after reset key", DEF_DIV, divider_t'(rd));
  endtask

  task automatic test_hex();
    apb_data_t rd;
    cur_test = "test_hex";
    hold_key(1, 2 * REPEAT + 1);
    repeat (2) @(posedge CLK_50M);
    reg_read(REG_DIVIDER, rd);
    for (int i = 0; i < HEX_DIGITS; i++)
      check_seg($sformatf("digit %0d", i), seg_of(rd[4*i +: 4]), hex[i]);
    hold_key(2, 1);
    repeat (2) @(posedge CLK_50M);
    for (int i = 0; i < HEX_DIGITS; i++)
      check_seg($sformatf("default digit %0d", i),
                seg_of(4'(DEF_DIV >> (4 * i))), hex[i]);
  endtask

  task automatic test_play();
    cur_test = "test_play";
    reg_write(REG_START, LOOP_START, 1'b0);
    reg_write(REG_END, LOOP_START + 2, 1'b0);
    got_samples.delete();
    got_cycles.delete();
    reg_write(REG_CTRL, 32'd1, 1'b0);
    reg_check(REG_CTRL, 32'd1);
    wait_samples(8);
    for (int i = 0; i < 8 && i < got_samples.size(); i++)
      check_sample($sformatf("sample %0d", i), sample_at(i), got_samples[i]);
    for (int i = 1; i < 8 && i < got_cycles.size(); i++)
      check_divider($sformatf("spacing %0d", i), DEF_DIV,
                    divider_t'(got_cycles[i] - got_cycles[i-1] - 1));
  endtask

  task automatic test_underrun();
    apb_data_t u0;
    apb_data_t u1;
    int        n0;
    int        gap;
    int        missed;
    cur_test = "test_underrun";
    wait_samples(got_samples.size() + 1);
    n0 = got_samples.size();
    reg_read(REG_UNDERRUN, u0);
    @(posedge CLK_50M);
    flash_waitrequest <= 1'b1;
    repeat (5 * (DEF_DIV + 1)) @(posedge CLK_50M);
    flash_waitrequest <= 1'b0;
    wait_samples(n0 + 4);
    reg_read(REG_UNDERRUN, u1);
    missed = 0;
    for (int i = n0; i < got_cycles.size(); i++)
    begin
      gap = got_cycles[i] - got_cycles[i-1];
      check_data($sformatf("gap %0d on tick grid", i), '0, apb_data_t'(gap % (DEF_DIV + 1)));
      missed += gap / (DEF_DIV + 1) - 1;
    end
    check_data("stall missed some ticks", 32'd1, apb_data_t'(missed > 0));
    check_data("underrun growth", apb_data_t'(missed), u1 - u0);
    for (int i = 0; i < got_samples.size(); i++)
      check_sample($sformatf("sample %0d", i), sample_at(i), got_samples[i]);
  endtask

  task automatic test_stop();
    int reads0;
    int samples0;
    cur_test = "test_stop";
    reg_write(REG_CTRL, 32'd0, 1'b0);
    repeat (10) @(posedge CLK_50M);
    reads0   = flash_reads;
    samples0 = got_samples.size();
    repeat (4 * (DEF_DIV + 1)) @(posedge CLK_50M);
    check_data("flash reads after stop", apb_data_t'(reads0), apb_data_t'(flash_reads));
    check_data("strobes after stop", apb_data_t'(samples0), apb_data_t'(got_samples.size()));
    check_data("flash_read after stop", '0, apb_data_t'(flash_read));
  endtask

  task automatic run_test(input int idx);
    int e0;
    e0 = errors;
    case (idx)
      0: test_regs();
      1: test_speed();
      2: test_hex();
      3: test_play();
      4: test_underrun();
      default: test_stop();
    endcase
    tests_run++;
    if (errors != e0)
      tests_failed++;
    $display("%s: %s", cur_test, (errors == e0) ? "ok" : "FAILED");
  endtask

  initial
  begin
    CLK_50M             = 1'b0;
    rst_n               = 1'b0;
    paddr               = '0;
    psel                = 1'b0;
    penable             = 1'b0;
    pwrite              = 1'b0;
    pwdata              = '0;
    speed_up            = 1'b0;
    speed_down          = 1'b0;
    speed_reset         = 1'b0;
    flash_waitrequest   = 1'b0;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    pending             = 1'b0;
    lat_cnt             = 0;
    pend_addr           = '0;
    cycle               = 0;
    errors              = 0;
    assert_errors       = 0;
    tests_run           = 0;
    tests_failed        = 0;
    flash_reads         = 0;
    lfsr                = 32'ha9e4_17c7;
    repeat (4) @(posedge CLK_50M);
    rst_n <= 1'b1;
    for (int t = 0; t < 6; t++)
      run_test(t);
    assert_errors = i_dut.flash_sample_fetch_inst.i_assertions.fail_count;
    $display("Tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, assert_errors);
    if (errors == 0 && assert_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
